// ==== common/pe_defines.svh ====
`ifndef PE_DEFINES_SVH
`define PE_DEFINES_SVH

// word width of one ieee double
`define PE_DWIDTH 64

// operands in to o_result out, in clocks
`define PE_LATENCY 4

// signed fixed-point accumulator format
`define ACC_INT_BITS 40
`define ACC_FRAC_BITS 40

`endif

// ==== common/pe_pkg.sv ====
`include "pe_defines.svh"

package pe_pkg;

  localparam int MANT_BITS = 52;                          // stored fraction bits
  localparam int EXP_BITS  = `PE_DWIDTH - 1 - MANT_BITS;  // 11 for a double
  localparam int EXP_BIAS  = (1 << (EXP_BITS - 1)) - 1;   // 1023
  localparam int EXP_MAX   = (1 << EXP_BITS) - 1;         // reserved inf/nan code

  typedef struct packed {
    logic                 sign;
    logic [EXP_BITS-1:0]  exp;
    logic [MANT_BITS-1:0] frac;
  } fp64_fields_t;

  // one double seen as raw bits or as its fields
  typedef union packed {
    logic [`PE_DWIDTH-1:0] raw;
    fp64_fields_t          f;
  } fp64_t;

  typedef enum logic [1:0] {
    OP_ADD   = 2'b00,
    OP_ACC_A = 2'b01,
    OP_MUL   = 2'b10,
    OP_ACC_B = 2'b11
  } pe_op_e;

endpackage

// ==== logic/fp_add_pipe.sv ====
`timescale 1ns/1ns
`include "pe_defines.svh"

module fp_add_pipe (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic [`PE_DWIDTH-1:0] i_a,
  input  logic [`PE_DWIDTH-1:0] i_b,
  output logic [`PE_DWIDTH-1:0] o_sum
);
  import pe_pkg::*;

  localparam int GRD = 3;                  // guard bits kept under the lsb
  localparam int MW  = MANT_BITS + 1 + GRD; // hidden + fraction + guard
  localparam int SW  = MW + 1;             // room for the carry out
  localparam int EW  = EXP_BITS + 2;       // signed exponent while normalizing
  localparam int LZW = $clog2(SW);         // leading zero count width

  fp64_t               a_w;
  fp64_t               b_w;
  logic                a_big;              // |a| >= |b|
  logic [EXP_BITS-1:0] exp_diff;
  logic [MW-1:0]       man_a;
  logic [MW-1:0]       man_b;
  logic [MW-1:0]       man_sml;            // aligned smaller mantissa

  logic                s1_sign_big;
  logic                s1_sign_sml;
  logic [EXP_BITS-1:0] s1_exp;
  logic [MW-1:0]       s1_man_big;
  logic [MW-1:0]       s1_man_sml;

  logic                s2_sign;
  logic [EXP_BITS-1:0] s2_exp;
  logic [SW-1:0]       s2_sum;

  logic [LZW-1:0]      lz;

  logic                s3_sign;
  logic                s3_zero;
  logic signed [EW-1:0] s3_exp;
  logic [SW-1:0]       s3_man;             // leading one at msb

  fp64_t               res;

  assign a_w = i_a;
  assign b_w = i_b;

  // subnormals flush to a zero mantissa
  assign man_a = (a_w.f.exp == '0) ? '0 : {1'b1, a_w.f.frac, {GRD{1'b0}}};
  assign man_b = (b_w.f.exp == '0) ? '0 : {1'b1, b_w.f.frac, {GRD{1'b0}}};

  assign a_big    = {a_w.f.exp, a_w.f.frac} >= {b_w.f.exp, b_w.f.frac}; // magnitude order
  assign exp_diff = a_big ? a_w.f.exp - b_w.f.exp : b_w.f.exp - a_w.f.exp;
  assign man_sml  = (a_big ? man_b : man_a) >> exp_diff; // big shifts drop to zero

  // stage 1 align
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      s1_sign_big <= 1'b0;
      s1_sign_sml <= 1'b0;
      s1_exp      <= '0;
      s1_man_big  <= '0;
      s1_man_sml  <= '0;
    end else begin
      s1_sign_big <= a_big ? a_w.f.sign : b_w.f.sign;
      s1_sign_sml <= a_big ? b_w.f.sign : a_w.f.sign;
      s1_exp      <= a_big ? a_w.f.exp : b_w.f.exp;
      s1_man_big  <= a_big ? man_a : man_b;
      s1_man_sml  <= man_sml;
    end
  end

  // stage 2 signed mantissa add
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      s2_sign <= 1'b0;
      s2_exp  <= '0;
      s2_sum  <= '0;
    end else begin
      s2_sign <= s1_sign_big;                      // larger operand sets the sign
      s2_exp  <= s1_exp;
      if (s1_sign_big ^ s1_sign_sml) begin
        s2_sum <= {1'b0, s1_man_big} - {1'b0, s1_man_sml}; // never negative
      end else begin
        s2_sum <= {1'b0, s1_man_big} + {1'b0, s1_man_sml};
      end
    end
  end

  // highest set bit wins
  always_comb begin
    lz = '0;
    for (int i = 0; i < SW; i++) begin
      if (s2_sum[i]) begin
        lz = LZW'(SW - 1 - i);
      end
    end
  end

  // stage 3 normalize
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      s3_sign <= 1'b0;
      s3_zero <= 1'b1;
      s3_exp  <= '0;
      s3_man  <= '0;
    end else begin
      s3_sign <= s2_sign;
      s3_zero <= (s2_sum == '0);                   // cancellation or two zeros
      s3_exp  <= EW'(s2_exp) + EW'(1) - EW'(lz);   // +1 for the carry position
      s3_man  <= s2_sum << lz;
    end
  end

  // pack, flush underflow, saturate overflow
  always_comb begin
    res.raw = '0;
    if (!s3_zero && s3_exp > 0) begin
      res.f.sign = s3_sign;
      if (s3_exp >= EXP_MAX) begin
        res.f.exp  = EXP_BITS'(EXP_MAX - 1);       // largest finite
        res.f.frac = '1;
      end else begin
        res.f.exp  = s3_exp[EXP_BITS-1:0];
        res.f.frac = s3_man[SW-2 -: MANT_BITS];    // truncate below
      end
    end
  end

  // stage 4 output
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_sum <= '0;
    end else begin
      o_sum <= res.raw;
    end
  end

endmodule

// ==== logic/fp_mul_pipe.sv ====
`timescale 1ns/1ns
`include "pe_defines.svh"

module fp_mul_pipe (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic [`PE_DWIDTH-1:0] i_a,
  input  logic [`PE_DWIDTH-1:0] i_b,
  output logic [`PE_DWIDTH-1:0] o_prod
);
  import pe_pkg::*;

  localparam int MW = MANT_BITS + 1;   // with hidden bit
  localparam int PW = 2 * MW;          // 106 bit product
  localparam int EW = EXP_BITS + 2;    // signed exponent sum

  fp64_t                a_w;
  fp64_t                b_w;

  logic                 s1_sign;
  logic                 s1_zero;
  logic signed [EW-1:0] s1_exp;
  logic [MW-1:0]        s1_man_a;
  logic [MW-1:0]        s1_man_b;

  logic                 s2_sign;
  logic                 s2_zero;
  logic signed [EW-1:0] s2_exp;
  logic [PW-1:0]        s2_prod;

  logic signed [EW-1:0] exp_n;
  logic [MANT_BITS-1:0] frac_n;
  fp64_t                res;

  assign a_w = i_a;
  assign b_w = i_b;

  // stage 1 sign and exponent
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      s1_sign  <= 1'b0;
      s1_zero  <= 1'b1;
      s1_exp   <= '0;
      s1_man_a <= '0;
      s1_man_b <= '0;
    end else begin
      s1_sign  <= a_w.f.sign ^ b_w.f.sign;
      s1_zero  <= (a_w.f.exp == '0) || (b_w.f.exp == '0); // zero or flushed subnormal
      s1_exp   <= EW'(a_w.f.exp) + EW'(b_w.f.exp) - EW'(EXP_BIAS);
      s1_man_a <= {1'b1, a_w.f.frac};
      s1_man_b <= {1'b1, b_w.f.frac};
    end
  end

  // stage 2 mantissa product
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      s2_sign <= 1'b0;
      s2_zero <= 1'b1;
      s2_exp  <= '0;
      s2_prod <= '0;
    end else begin
      s2_sign <= s1_sign;
      s2_zero <= s1_zero;
      s2_exp  <= s1_exp;
      s2_prod <= s1_man_a * s1_man_b;  // in [1,4) scaled
    end
  end

  // product below 2 needs no shift
  assign exp_n  = s2_exp + EW'(s2_prod[PW-1]);
  assign frac_n = s2_prod[PW-1] ? s2_prod[PW-2 -: MANT_BITS] : s2_prod[PW-3 -: MANT_BITS];

  always_comb begin
    res.raw = '0;
    if (!s2_zero && exp_n > 0) begin   // underflow flushes
      res.f.sign = s2_sign;
      if (exp_n >= EXP_MAX) begin
        res.f.exp  = EXP_BITS'(EXP_MAX - 1); // saturate
        res.f.frac = '1;
      end else begin
        res.f.exp  = exp_n[EXP_BITS-1:0];
        res.f.frac = frac_n;
      end
    end
  end

  // stage 3 output
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_prod <= '0;
    end else begin
      o_prod <= res.raw;
    end
  end

endmodule

// ==== fp_accum/fp_accum.sv ====
`timescale 1ns/1ns
`include "pe_defines.svh"

module fp_accum (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic [`PE_DWIDTH-1:0] i_a,
  input  logic [`PE_DWIDTH-1:0] i_b,
  input  pe_pkg::pe_op_e        i_op,
  input  logic                  i_acc_clr,
  output logic [`PE_DWIDTH-1:0] o_acc
);
  import pe_pkg::*;

  localparam int ACC_W = `ACC_INT_BITS + `ACC_FRAC_BITS; // whole fixed-point word
  localparam int WIDE  = ACC_W + MANT_BITS;               // room below a short sum

  fp64_t                   term_w;
  logic                    is_acc;
  logic [MANT_BITS:0]      term_man;
  logic [ACC_W-1:0]        term_mag;
  int                      term_shift;  // hidden bit lands at MANT_BITS + shift

  logic signed [ACC_W-1:0] s1_term;
  logic                    s1_clr;
  logic signed [ACC_W-1:0] r_sum;

  logic                    sum_sign;
  logic [ACC_W-1:0]        sum_mag;
  int                      lead;         // highest set bit of sum_mag
  int                      sum_exp;
  logic [WIDE-1:0]         sum_norm;
  fp64_t                   res;

  assign term_w   = i_op[1] ? i_b : i_a;                 // b for OP_ACC_B
  assign is_acc   = (i_op == OP_ACC_A) || (i_op == OP_ACC_B);
  assign term_man = {1'b1, term_w.f.frac};

  // float to fixed
  always_comb begin
    term_shift = int'(term_w.f.exp) - EXP_BIAS + `ACC_FRAC_BITS - MANT_BITS;
    if (term_shift >= 0) begin
      term_mag = ACC_W'(term_man) << term_shift;         // high bits wrap out
    end else begin
      term_mag = ACC_W'(term_man >> -term_shift);        // fine bits truncated
    end
  end

  // stage 1 term select
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      s1_term <= '0;
      s1_clr  <= 1'b0;
    end else begin
      if (!is_acc || term_w.f.exp == '0) begin
        s1_term <= '0;                                   // add/mul or zero term
      end else if (term_w.f.sign) begin
        s1_term <= -$signed(term_mag);
      end else begin
        s1_term <= $signed(term_mag);
      end
      s1_clr <= i_acc_clr;                               // stays with its term
    end
  end

  // stage 2 running sum, one term per clock
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      r_sum <= '0;
    end else begin
      r_sum <= (s1_clr ? '0 : r_sum) + s1_term;         // clear then add
    end
  end

  // fixed to float
  assign sum_sign = r_sum[ACC_W-1];
  assign sum_mag  = sum_sign ? -r_sum : r_sum;

  always_comb begin
    lead = 0;
    for (int i = 0; i < ACC_W; i++) begin
      if (sum_mag[i]) begin
        lead = i;
      end
    end
    sum_exp  = lead - `ACC_FRAC_BITS + EXP_BIAS;
    sum_norm = {sum_mag << (ACC_W - 1 - lead), {MANT_BITS{1'b0}}}; // lead one at top
  end

  always_comb begin
    res.raw = '0;
    if (sum_mag != '0 && sum_exp > 0) begin
      res.f.sign = sum_sign;
      if (sum_exp >= EXP_MAX) begin
        res.f.exp  = EXP_BITS'(EXP_MAX - 1);             // only for very wide formats
        res.f.frac = '1;
      end else begin
        res.f.exp  = EXP_BITS'(sum_exp);
        res.f.frac = sum_norm[WIDE-2 -: MANT_BITS];      // bits below the hidden one
      end
    end
  end

  // stage 3 output
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_acc <= '0;
    end else begin
      o_acc <= res.raw;
    end
  end

endmodule

// ==== logic/pe_result_select.sv ====
`timescale 1ns/1ns
`include "pe_defines.svh"

module pe_result_select (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  pe_pkg::pe_op_e        i_op,
  input  logic [`PE_DWIDTH-1:0] i_add,    // adder, already at full latency
  input  logic [`PE_DWIDTH-1:0] i_mul,    // one clock early
  input  logic [`PE_DWIDTH-1:0] i_acc,    // one clock early
  output logic [`PE_DWIDTH-1:0] o_result
);
  import pe_pkg::*;

  localparam int OP_DLY = `PE_LATENCY - 1; // matches mul and accum depth

  pe_op_e                op_dly [OP_DLY];
  pe_op_e                op_late;
  logic [`PE_DWIDTH-1:0] alt_nxt;
  logic [`PE_DWIDTH-1:0] r_alt;           // aligned mul or acc result
  logic                  r_pick_add;

  assign op_late = op_dly[OP_DLY-1];

  always_comb begin
    case (op_late)
      OP_MUL:   alt_nxt = i_mul;
      OP_ACC_A: alt_nxt = i_acc;
      OP_ACC_B: alt_nxt = i_acc;
      default:  alt_nxt = '0;             // add path bypasses this register
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < OP_DLY; i++) begin
        op_dly[i] <= OP_ADD;
      end
      r_alt      <= '0;
      r_pick_add <= 1'b1;
    end else begin
      op_dly[0] <= i_op;
      for (int i = 1; i < OP_DLY; i++) begin
        op_dly[i] <= op_dly[i-1];
      end
      r_alt      <= alt_nxt;
      r_pick_add <= (op_late == OP_ADD);
    end
  end

  assign o_result = r_pick_add ? i_add : r_alt; // adder joins after the register

endmodule

// ==== logic/pe_double.sv ====
`timescale 1ns/1ns
`include "pe_defines.svh"

module pe_double (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic [`PE_DWIDTH-1:0] i_op_a,
  input  logic [`PE_DWIDTH-1:0] i_op_b,
  input  pe_pkg::pe_op_e        i_op,
  input  logic                  i_acc_clr,  // restart the running sum
  output logic [`PE_DWIDTH-1:0] o_result
);

  logic [`PE_DWIDTH-1:0] add_res;   // 4 clocks
  logic [`PE_DWIDTH-1:0] mul_res;   // 3 clocks
  logic [`PE_DWIDTH-1:0] acc_res;   // 3 clocks

  // all units see every operand pair
  fp_add_pipe u_add (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_a     (i_op_a),
    .i_b     (i_op_b),
    .o_sum   (add_res)
  );

  fp_mul_pipe u_mul (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_a     (i_op_a),
    .i_b     (i_op_b),
    .o_prod  (mul_res)
  );

  fp_accum u_acc (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_a       (i_op_a),
    .i_b       (i_op_b),
    .i_op      (i_op),
    .i_acc_clr (i_acc_clr),
    .o_acc     (acc_res)
  );

  pe_result_select u_sel (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_op     (i_op),
    .i_add    (add_res),
    .i_mul    (mul_res),
    .i_acc    (acc_res),
    .o_result (o_result)
  );

endmodule

// ==== tb/tb_pe_double.sv ====
`timescale 1ns/1ns
`include "pe_defines.svh"

module tb_pe_double;
  import pe_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 10;
  localparam int LAT        = `PE_LATENCY;
  localparam int MAX_ENT    = 64;          // table capacity
  localparam int SEED       = 12028;

  logic                  clk;
  logic                  i_rst_n;
  logic [`PE_DWIDTH-1:0] i_op_a;
  logic [`PE_DWIDTH-1:0] i_op_b;
  pe_op_e                i_op;
  logic                  i_acc_clr;
  logic [`PE_DWIDTH-1:0] o_result;

  // one row per applied operation
  string                 t_name [MAX_ENT];
  pe_op_e                t_op   [MAX_ENT];
  logic                  t_clr  [MAX_ENT];
  logic [`PE_DWIDTH-1:0] t_a    [MAX_ENT];
  logic [`PE_DWIDTH-1:0] t_b    [MAX_ENT];
  logic [`PE_DWIDTH-1:0] t_exp  [MAX_ENT];
  int                    n_ent;
  logic                  table_ready;       // releases the watchdog

  pe_double DUT (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_op_a    (i_op_a),
    .i_op_b    (i_op_b),
    .i_op      (i_op),
    .i_acc_clr (i_acc_clr),
    .o_result  (o_result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // filler for the operand an accumulate ignores
  function automatic logic [`PE_DWIDTH-1:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  task automatic check_val(input string name, input logic [`PE_DWIDTH-1:0] exp_val,
                           input logic [`PE_DWIDTH-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("ERROR %s: expected %h actual %h", name, exp_val, act_val);
      $display("TEST FAIL");
      $fatal(1, "result mismatch");
    end
  endtask

  // operands and result given as exact dyadic reals
  task automatic add_entry(input string name, input pe_op_e op, input logic clr,
                           input real a, input real b, input real res);
    t_name[n_ent] = name;
    t_op[n_ent]   = op;
    t_clr[n_ent]  = clr;
    t_a[n_ent]    = (op == OP_ACC_B) ? rand_word() : $realtobits(a); // unused for acc b
    t_b[n_ent]    = (op == OP_ACC_A) ? rand_word() : $realtobits(b); // unused for acc a
    t_exp[n_ent]  = $realtobits(res);
    n_ent++;
  endtask

  task automatic load_table();
    // adds over both exponent cases and signs down to cancellation
    add_entry("add_eq_exp",     OP_ADD,   1'b0,  1.5,    1.25,   2.75);
    add_entry("add_uneq_exp",   OP_ADD,   1'b0,  3.0,    0.125,  3.125);
    add_entry("add_mixed_sign", OP_ADD,   1'b0,  1.5,   -2.25,  -0.75);
    add_entry("add_neg_big",    OP_ADD,   1'b0, -3.0,    1.0,   -2.0);
    add_entry("add_both_neg",   OP_ADD,   1'b0, -4.5,   -0.375, -4.875);
    add_entry("add_cancel",     OP_ADD,   1'b0,  1.5,   -1.25,   0.25);
    add_entry("add_negation",   OP_ADD,   1'b0,  3.75,  -3.75,   0.0);
    add_entry("add_zero",       OP_ADD,   1'b0,  0.0,    1.25,   1.25);
    // multiply with mixed signs and zeros and a one-bit normalize
    add_entry("mul_pos",        OP_MUL,   1'b0,  0.125,  4.0,    0.5);
    add_entry("mul_mixed",      OP_MUL,   1'b0,  1.5,   -2.25,  -3.375);
    add_entry("mul_neg_neg",    OP_MUL,   1'b0, -1.5,   -0.5,    0.75);
    add_entry("mul_norm",       OP_MUL,   1'b0,  1.5,    1.5,    2.25);
    add_entry("mul_norm_neg",   OP_MUL,   1'b0,  3.0,   -3.0,   -9.0);
    add_entry("mul_norm_frac",  OP_MUL,   1'b0,  1.75,   1.75,   3.0625);
    add_entry("mul_zero_a",     OP_MUL,   1'b0,  0.0,   -3.0,    0.0);  // unsigned zero out
    add_entry("mul_zero_b",     OP_MUL,   1'b0,  2.5,    0.0,    0.0);
    // clear then a run of a terms
    add_entry("acc_a_clr",      OP_ACC_A, 1'b1,  1.5,    0.0,    1.5);
    add_entry("acc_a_2",        OP_ACC_A, 1'b0,  2.25,   0.0,    3.75);
    add_entry("acc_a_3",        OP_ACC_A, 1'b0, -0.125,  0.0,    3.625);
    add_entry("acc_a_4",        OP_ACC_A, 1'b0, -5.0,    0.0,   -1.375);
    // b terms continue the same sum
    add_entry("acc_b_1",        OP_ACC_B, 1'b0,  0.0,    0.5,   -0.875);
    add_entry("acc_b_2",        OP_ACC_B, 1'b0,  0.0,    3.0,    2.125);
    add_entry("acc_b_3",        OP_ACC_B, 1'b0,  0.0,   -0.375,  1.75);
    // mixed ops back to back while the sum holds across add and mul
    add_entry("mix_add",        OP_ADD,   1'b0,  2.0,    0.5,    2.5);
    add_entry("mix_acc_a",      OP_ACC_A, 1'b0,  0.25,   0.0,    2.0);
    add_entry("mix_mul",        OP_MUL,   1'b0,  2.5,   -2.0,   -5.0);
    add_entry("mix_acc_b",      OP_ACC_B, 1'b0,  0.0,    1.0,    3.0);
    add_entry("mix_add_neg",    OP_ADD,   1'b0, -1.0,   -0.25,  -1.25);
    add_entry("mix_mul_neg",    OP_MUL,   1'b0, -0.5,   -0.5,    0.25);
    add_entry("mix_acc_clr",    OP_ACC_A, 1'b1,  6.0,    0.0,    6.0);  // restart from term
    add_entry("mix_add_2",      OP_ADD,   1'b0, 10.0,   -6.75,   3.25);
    add_entry("mix_acc_b_2",    OP_ACC_B, 1'b0,  0.0,   -1.25,   4.75);
    add_entry("mix_mul_2",      OP_MUL,   1'b0,  7.0,    0.375,  2.625);
    add_entry("mix_acc_zero",   OP_ACC_A, 1'b0,  0.0,    0.0,    4.75);
  endtask

  task automatic apply_entry(input int idx);
    i_op_a    = t_a[idx];
    i_op_b    = t_b[idx];
    i_op      = t_op[idx];
    i_acc_clr = t_clr[idx];
  endtask

  task automatic drive_idle();
    i_op_a    = '0;
    i_op_b    = '0;
    i_op      = OP_ADD;                    // zero plus zero leaves the sum untouched
    i_acc_clr = 1'b0;
  endtask

  initial begin
    i_rst_n     = 1'b0;
    drive_idle();
    n_ent       = 0;
    table_ready = 1'b0;
    void'($urandom(SEED));                 // single seed for the run
    load_table();
    table_ready = 1'b1;

    for (int cyc = 0; cyc < RST_CYCLES; cyc++) begin
      @(posedge clk);
      #2;
      check_val("reset", '0, o_result);
      apply_entry(cyc % n_ent);            // live operands that reset has to mask
    end
    i_rst_n = 1'b1;
    drive_idle();

    // row k goes in at cycle k and comes out LAT edges later
    for (int cyc = 0; cyc < n_ent + LAT; cyc++) begin
      @(posedge clk);
      #2;                                  // outputs settled before new inputs
      if (cyc < LAT) begin
        check_val("after_reset", '0, o_result);
      end else begin
        check_val(t_name[cyc-LAT], t_exp[cyc-LAT], o_result);
      end
      if (cyc < n_ent) begin
        apply_entry(cyc);
      end else begin
        drive_idle();
      end
    end

    $display("TEST PASS");
    $finish;
  end

  // watchdog sized from the table
  initial begin
    wait (table_ready);
    #((n_ent + LAT + 20) * CLK_PERIOD);
    $display("timeout: the run did not finish within the expected number of cycles");
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== files.f ====
+incdir+common
common/pe_pkg.sv
logic/fp_add_pipe.sv
logic/fp_mul_pipe.sv
fp_accum/fp_accum.sv
logic/pe_result_select.sv
logic/pe_double.sv
tb/tb_pe_double.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pe_double testbench with verilator
set -e

cd "$(dirname "$0")"

TOP=tb_pe_double
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --top-module "$TOP" -f files.f

# a fatal stop exits nonzero, the log decides the verdict
./obj_dir/V"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

if ! grep -q "TEST PASS" "$LOG"; then
  echo "simulation ended without a verdict"
  exit 1
fi

echo "simulation passed"
